/* clint/clint_timer.sv */
`default_nettype none

`include "soc_defines.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   sel_i,
  input  soc_bus_pkg::bus_req_t  req_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic                   rtc_q;
  logic [`SOC_DATA_W-1:0] mtime_q;
  logic [`SOC_DATA_W-1:0] mtimecmp_q;
  logic                   msip_q;
  clint_off_e             off;
  logic [`SOC_DATA_W-1:0] wr_word;
  logic                   wr_en;

  assign off     = clint_off_e'({req_i.addr[15:3], 3'b000});  // 64-bit registers
  assign wr_en   = sel_i && (req_i.op == BUS_WRITE);
  assign wr_word = apply_be(rdata_o, req_i.wdata, req_i.be);

  // Register readback
  always_comb begin
    rdata_o = '0;
    case (off)
      OFF_MSIP:     rdata_o[0] = msip_q;
      OFF_MTIMECMP: rdata_o    = mtimecmp_q;
      OFF_MTIME:    rdata_o    = mtime_q;
      default:      rdata_o    = '0;
    endcase
  end

  // --------------------------------------------------
  // RTC and timer registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // No interrupt until programmed
      msip_q     <= 1'b0;
    end else begin
      rtc_q <= ~rtc_q;  // Half the clock rate

      if (wr_en && (off == OFF_MTIME)) begin
        mtime_q <= wr_word;
      end else if (rtc_q) begin
        mtime_q <= mtime_q + 1'b1;
      end

      if (wr_en && (off == OFF_MTIMECMP)) mtimecmp_q <= wr_word;
      if (wr_en && (off == OFF_MSIP))     msip_q     <= wr_word[0];
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

/* common/soc_bus_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_bus_pkg;

  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  typedef struct packed {
    logic                   req;    // One-cycle strobe
    bus_op_e                op;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                   valid;
    logic                   err;    // Decode error
    logic [`SOC_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Merge the enabled bytes of a write into the current register value
  function automatic logic [`SOC_DATA_W-1:0] apply_be(
    input logic [`SOC_DATA_W-1:0] old_word,
    input logic [`SOC_DATA_W-1:0] new_word,
    input logic [`SOC_BE_W-1:0]   be
  );
    logic [`SOC_DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `SOC_BE_W; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* common/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define SOC_ADDR_W        32
`define SOC_DATA_W        64
`define SOC_BE_W          8

// Power-on reset counter, saturates after 64 cycles
`define SOC_RST_CNT_W     6

// Boot RAM depth in 64-bit words
`define SOC_BOOT_WORDS    512

// Fan PWM
`define SOC_FAN_PERIOD_W  4   // 16-cycle period
`define SOC_FAN_DEFAULT   8

// Memory map
`define SOC_ROM_BASE      32'h0001_0000
`define SOC_ROM_LEN       32'h0000_1000
`define SOC_CLINT_BASE    32'h0200_0000
`define SOC_CLINT_LEN     32'h0000_C000
`define SOC_GPIO_BASE     32'h4000_0000
`define SOC_GPIO_LEN      32'h0000_1000

`endif

/* common/soc_map_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_map_pkg;

  localparam int unsigned NUM_SLV = 3;

  // Slave targets, the value doubles as the index into the rdata vector
  typedef enum logic [1:0] {
    REG_ROM   = 2'd0,
    REG_CLINT = 2'd1,
    REG_GPIO  = 2'd2,
    REG_NONE  = 2'd3
  } region_e;

  typedef logic [NUM_SLV-1:0][`SOC_DATA_W-1:0] slave_rsp_vec_t;

  // --------------------------------------------------
  // Register offsets inside a region
  // --------------------------------------------------
  typedef enum logic [15:0] {
    OFF_MSIP     = 16'h0000,
    OFF_MTIMECMP = 16'h4000,
    OFF_MTIME    = 16'hBFF8
  } clint_off_e;

  typedef enum logic [11:0] {
    OFF_LED = 12'h000,
    OFF_SW  = 12'h008,  // Read only
    OFF_FAN = 12'h010
  } gpio_off_e;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_soc -o Vtb_soc

out=$(./obj_dir/Vtb_soc)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi

/* src/boot_ram.sv */
`default_nettype none

`include "soc_defines.svh"

module boot_ram (
  input  logic                   clk,
  input  logic                   sel_i,
  input  soc_bus_pkg::bus_req_t  req_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);
  import soc_bus_pkg::*;

  localparam int unsigned IDX_W = $clog2(`SOC_BOOT_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_BOOT_WORDS];
  logic [IDX_W-1:0]       word_idx;

  assign word_idx = req_i.addr[IDX_W+2:3];  // Byte offset to word index

  always_ff @(posedge clk) begin
    if (sel_i) begin
      if (req_i.op == BUS_WRITE) begin
        for (int b = 0; b < `SOC_BE_W; b++) begin
          if (req_i.be[b]) mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_o <= mem[word_idx];  // Holds until the next read
      end
    end
  end

endmodule

`default_nettype wire

/* src/periph_regs.sv */
`default_nettype none

`include "soc_defines.svh"

module periph_regs (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   sel_i,
  input  soc_bus_pkg::bus_req_t  req_i,
  input  logic [7:0]             sw_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic [7:0]             led_o,
  output logic                   fan_pwm_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [7:0]                   led_q;
  logic [`SOC_FAN_PERIOD_W-1:0] fan_q;
  logic [`SOC_FAN_PERIOD_W-1:0] pwm_cnt_q;
  gpio_off_e                    off;
  logic [`SOC_DATA_W-1:0]       wr_word;
  logic                         wr_en;

  assign off     = gpio_off_e'({req_i.addr[11:3], 3'b000});
  assign wr_en   = sel_i && (req_i.op == BUS_WRITE);
  assign wr_word = apply_be(rdata_o, req_i.wdata, req_i.be);

  always_comb begin
    rdata_o = '0;
    case (off)
      OFF_LED: rdata_o[7:0]                   = led_q;
      OFF_SW:  rdata_o[7:0]                   = sw_i;
      OFF_FAN: rdata_o[`SOC_FAN_PERIOD_W-1:0] = fan_q;
      default: rdata_o                        = '0;
    endcase
  end

  // --------------------------------------------------
  // LED and fan setting registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      led_q <= '0;
      fan_q <= `SOC_FAN_PERIOD_W'(`SOC_FAN_DEFAULT);
    end else if (wr_en) begin
      case (off)
        OFF_LED: led_q <= wr_word[7:0];
        OFF_FAN: fan_q <= wr_word[`SOC_FAN_PERIOD_W-1:0];
        default: ;  // Switches are read only
      endcase
    end
  end

  // Fan PWM
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pwm_cnt_q <= '0;
    end else begin
      pwm_cnt_q <= pwm_cnt_q + 1'b1;  // Wraps every 16 cycles
    end
  end

  // Duty is fan_q out of the period
  assign fan_pwm_o = (pwm_cnt_q < fan_q);
  assign led_o     = led_q;

endmodule

`default_nettype wire

/* src/rst_seq.sv */
`default_nettype none

`include "soc_defines.svh"

module rst_seq (
  input  logic clk,
  input  logic cpu_resetn,
  input  logic clk_locked_i,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic [`SOC_RST_CNT_W-1:0] por_cnt_q;
  logic                      por_done_q;
  logic                      merged_rst_n;
  logic [1:0]                sync_q;

  // Power-on count, then wait for the clock to lock
  always_ff @(posedge clk or negedge cpu_resetn) begin
    if (!cpu_resetn) begin
      por_cnt_q  <= '0;
      por_done_q <= 1'b0;
    end else begin
      if (!(&por_cnt_q)) por_cnt_q <= por_cnt_q + 1'b1;  // Saturate at all ones
      if ((&por_cnt_q) && clk_locked_i) begin
        por_done_q <= 1'b1;
      end
    end
  end

  // Debug reset joins here, asserts at once
  assign merged_rst_n = cpu_resetn & por_done_q & ~ndmreset_i;

  // Two-stage synchronizer on release
  always_ff @(posedge clk or negedge merged_rst_n) begin
    if (!merged_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

`default_nettype wire

/* src/soc_top.sv */
`default_nettype none

module soc_top (
  input  logic                   clk,
  input  logic                   cpu_resetn,
  input  logic                   clk_locked_i,
  input  logic                   ndmreset_i,   // Debug reset request
  input  soc_bus_pkg::bus_req_t  bus_req_i,
  output soc_bus_pkg::bus_rsp_t  bus_rsp_o,
  input  logic [7:0]             sw_i,
  output logic [7:0]             led_o,
  output logic                   fan_pwm_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic           sys_rst_n;
  logic           rom_sel;
  logic           clint_sel;
  logic           gpio_sel;
  bus_req_t       slv_req;     // Offset within the region
  slave_rsp_vec_t slv_rdata;

  rst_seq i_rst_seq (
    .clk          ( clk          ),
    .cpu_resetn   ( cpu_resetn   ),
    .clk_locked_i ( clk_locked_i ),
    .ndmreset_i   ( ndmreset_i   ),
    .sys_rst_no   ( sys_rst_n    )
  );

  // --------------------------------------------------
  // Bus fabric
  // --------------------------------------------------
  bus_xbar i_bus_xbar (
    .clk         ( clk       ),
    .rst_ni      ( sys_rst_n ),
    .bus_req_i   ( bus_req_i ),
    .bus_rsp_o   ( bus_rsp_o ),
    .rom_sel_o   ( rom_sel   ),
    .clint_sel_o ( clint_sel ),
    .gpio_sel_o  ( gpio_sel  ),
    .slv_req_o   ( slv_req   ),
    .slv_rdata_i ( slv_rdata )
  );

  // --------------------------------------------------
  // Slaves
  // --------------------------------------------------
  boot_ram i_boot_ram (
    .clk     ( clk                )    ,
    .sel_i   ( rom_sel            ),
    .req_i   ( slv_req            ),
    .rdata_o ( slv_rdata[REG_ROM] )
  );

  clint_timer i_clint_timer (
    .clk         ( clk                  ),
    .rst_ni      ( sys_rst_n            ),
    .sel_i       ( clint_sel            ),
    .req_i       ( slv_req              ),
    .rdata_o     ( slv_rdata[REG_CLINT] ),
    .timer_irq_o ( timer_irq_o          ),
    .ipi_o       ( ipi_o                )
  );

  periph_regs i_periph_regs (
    .clk       ( clk                 ),
    .rst_ni    ( sys_rst_n           ),
    .sel_i     ( gpio_sel            ),
    .req_i     ( slv_req             ),
    .sw_i      ( sw_i                ),
    .rdata_o   ( slv_rdata[REG_GPIO] ),
    .led_o     ( led_o               ),
    .fan_pwm_o ( fan_pwm_o           )
  );

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
src/rst_seq.sv
xbar/bus_xbar.sv
clint/clint_timer.sv
src/boot_ram.sv
src/periph_regs.sv
src/soc_top.sv
tb/tb_soc.sv

/* tb/soc_trace.txt */
# Columns: op addr data expect, all hex; a test line names the test instead
# read/write: expect is read data; lock: data is level, expect cycles watched; ndm: data pulse
# irqwait: addr 0 timer 1 ipi, data timeout; pwm: addr skip, data window, expect high count
test reset_gating
lock     00000000  0                 c8
lock     00000000  1                 0
read     40000008  0                 a5
test boot_ram
ram      00000000  28                0
write    00010008  0123456789abcdef  0
read     00010008  0                 0123456789abcdef
test decode
read     00000000  0                 0
write    30000000  1                 0
read     00011000  0                 0
write    40000000  3c                0
read     00010008  0                 0123456789abcdef
read     40000000  0                 3c
read     02000000  0                 0
read     40000008  0                 a5
read     7fff0000  0                 0
test clint
write    02004000  0                 0
irqwait  00000000  14                1
read     02004000  0                 0
write    02004000  ffffffffffffffff  0
irqwait  00000000  14                0
write    02000000  1                 0
irqwait  00000001  a                 1
read     02000000  0                 1
write    02000000  0                 0
irqwait  00000001  a                 0
mtime    0200bff8  a                 5
test gpio_fan_ndm
pwm      00000003  10                8
write    40000010  3                 0
read     40000010  0                 3
pwm      00000005  10                3
write    40000000  5a                0
led      00000000  0                 5a
ndm      00000000  4                 0
led      00000000  0                 0
read     40000010  0                 8
pwm      00000002  10                8
read     02004000  0                 ffffffffffffffff

/* tb/tb_soc.sv */
`default_nettype none

`include "soc_defines.svh"

module tb_soc;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_bus_pkg::*;

  localparam int MODE_NONE    = 0;
  localparam int MODE_CHECK   = 1;  // Compare with exp_q
  localparam int MODE_GATED   = 2;  // No response allowed
  localparam int MODE_CAPTURE = 3;  // Keep whatever comes back
  localparam logic [31:0] SW_ADDR = `SOC_GPIO_BASE + 32'h8;

  logic        clk;
  logic        cpu_resetn;
  logic        clk_locked;
  logic        ndmreset;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic [7:0]  sw;
  logic [7:0]  led;
  logic        fan_pwm;
  logic        timer_irq;
  logic        ipi;

  int          req_mode;
  int          pend_mode = MODE_NONE;  // Mode of the request seen one cycle back
  bus_rsp_t    exp_q[$];
  bus_rsp_t    cap_q[$];
  logic [63:0] ram_model [int];
  logic [31:0] rng_state = 32'h95029696;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          line_no = 0;
  int          test_err0 = 0;
  logic        in_test = 1'b0;
  logic [127:0] test_name;

  soc_top dut (
    .clk          ( clk        ),
    .cpu_resetn   ( cpu_resetn ),
    .clk_locked_i ( clk_locked ),
    .ndmreset_i   ( ndmreset   ),
    .bus_req_i    ( bus_req    ),
    .bus_rsp_o    ( bus_rsp    ),
    .sw_i         ( sw         ),
    .led_o        ( led        ),
    .fan_pwm_o    ( fan_pwm    ),
    .timer_irq_o  ( timer_irq  ),
    .ipi_o        ( ipi        )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers and compare tasks
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w, input logic [63:0] new_w,
                                              input logic [7:0] be);
    logic [63:0] m;
    m = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  function automatic logic in_map(input logic [31:0] a);
    return (a >= `SOC_ROM_BASE && a < `SOC_ROM_BASE + `SOC_ROM_LEN) ||
           (a >= `SOC_CLINT_BASE && a < `SOC_CLINT_BASE + `SOC_CLINT_LEN) ||
           (a >= `SOC_GPIO_BASE && a < `SOC_GPIO_BASE + `SOC_GPIO_LEN);
  endfunction

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp);
    if (got.valid !== exp.valid) begin
      $display("** Error bus_rsp_o.valid: got 0x%h, expected 0x%h (trace line %0d)",
               got.valid, exp.valid, line_no);
      err_cnt++;
    end else if (got.err !== exp.err || got.rdata !== exp.rdata) begin
      $display("** Error bus_rsp_o err/rdata: got 0x%h/0x%h, expected 0x%h/0x%h (trace line %0d)",
               got.err, got.rdata, exp.err, exp.rdata, line_no);
      err_cnt++;
    end
  endtask

  task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error led_o: got 0x%h, expected 0x%h (trace line %0d)", got, exp, line_no);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h (trace line %0d)", name, got, exp, line_no);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // Bus driving, one request per rising edge
  // --------------------------------------------------
  task automatic issue(input bus_op_e op, input logic [31:0] addr, input logic [63:0] wdata,
                       input logic [7:0] be, input int mode);
    @(posedge clk);
    bus_req  <= '{req: 1'b1, op: op, addr: addr, be: be, wdata: wdata};
    req_mode <= mode;
  endtask

  task automatic issue_checked(input bus_op_e op, input logic [31:0] addr,
                               input logic [63:0] wdata, input logic [7:0] be,
                               input logic [63:0] rexp);
    bus_rsp_t e;
    e.valid = 1'b1;
    e.err   = !in_map(addr);
    e.rdata = (op == BUS_READ && in_map(addr)) ? rexp : '0;  // Writes and errors give zero
    exp_q.push_back(e);
    issue(op, addr, wdata, be, MODE_CHECK);
  endtask

  task automatic go_idle();
    @(posedge clk);
    bus_req.req <= 1'b0;
    req_mode    <= MODE_NONE;
  endtask

  task automatic drain();
    int waited;
    go_idle();
    waited = 0;
    while ((pend_mode != MODE_NONE || exp_q.size() != 0) && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (pend_mode != MODE_NONE || exp_q.size() != 0) begin
      $display("Responses still outstanding after 20 idle cycles (trace line %0d)", line_no);
      err_cnt++;
    end
  endtask

  // Polls the switch register until the fabric answers
  task automatic wait_release(input int limit);
    int   tries;
    logic released;
    tries    = 0;
    released = 1'b0;
    while (!released && tries < limit) begin
      cap_q.delete();
      issue(BUS_READ, SW_ADDR, '0, '0, MODE_CAPTURE);
      go_idle();
      @(posedge clk);
      released = (cap_q.size() > 0);
      tries++;
    end
    if (!released) begin
      $display("System reset was not released after %0d polls (trace line %0d)", limit, line_no);
      err_cnt++;
    end
    cap_q.delete();
  endtask

  // Response monitor, samples at the falling edge
  always @(negedge clk) begin
    if (pend_mode == MODE_CHECK && exp_q.size() > 0) begin
      check_rsp(bus_rsp, exp_q.pop_front());
    end else if (pend_mode == MODE_CAPTURE) begin
      if (bus_rsp.valid === 1'b1) cap_q.push_back(bus_rsp);
    end else if (bus_rsp.valid === 1'b1) begin
      $display("Response on bus_rsp_o without an answerable request (trace line %0d)", line_no);
      err_cnt++;
    end
    pend_mode = bus_req.req ? req_mode : MODE_NONE;
  end

  // --------------------------------------------------
  // Trace operations
  // --------------------------------------------------
  task automatic run_lock(input logic level, input int cycles);
    @(posedge clk);
    clk_locked <= level;
    if (!level) begin
      repeat (cycles) issue(BUS_READ, SW_ADDR, '0, '0, MODE_GATED);
      drain();
    end else begin
      wait_release(100);
    end
  endtask

  task automatic run_ndm(input int len);
    @(posedge clk);
    ndmreset <= 1'b1;
    repeat (len) @(posedge clk);
    ndmreset <= 1'b0;
    wait_release(100);
  endtask

  task automatic run_ram(input int count);
    int          idx;
    logic [31:0] addr;
    logic [31:0] r;
    logic [63:0] wd;
    for (int i = 0; i < count; i++) begin
      r    = next_rand();
      idx  = int'(r % `SOC_BOOT_WORDS);
      addr = `SOC_ROM_BASE + 32'(idx * 8);
      if (!ram_model.exists(idx)) begin  // Fill an untouched word first
        wd = {next_rand(), next_rand()};
        issue_checked(BUS_WRITE, addr, wd, 8'hff, '0);
        ram_model[idx] = wd;
      end
      wd = {next_rand(), next_rand()};
      r  = next_rand();
      issue_checked(BUS_WRITE, addr, wd, r[7:0], '0);
      ram_model[idx] = merge_bytes(ram_model[idx], wd, r[7:0]);
      issue_checked(BUS_READ, addr, '0, '0, ram_model[idx]);
    end
  endtask

  task automatic run_irqwait(input logic which, input int timeout, input logic level);
    logic got;
    int   waited;
    waited = 0;
    @(negedge clk);
    got = which ? ipi : timer_irq;
    while (got !== level && waited < timeout) begin
      @(negedge clk);
      got = which ? ipi : timer_irq;
      waited++;
    end
    if (got !== level) $display("Interrupt did not settle within %0d cycles", timeout);
    check_bit(which ? "ipi_o" : "timer_irq_o", 5'(got), 5'(level));
  endtask

  task automatic run_mtime(input logic [31:0] addr, input int gap, input logic [63:0] delta);
    bus_rsp_t e;
    cap_q.delete();
    issue(BUS_READ, addr, '0, '0, MODE_CAPTURE);
    go_idle();
    repeat (gap - 2) @(posedge clk);
    issue(BUS_READ, addr, '0, '0, MODE_CAPTURE);  // Exactly gap cycles after the first
    drain();
    if (cap_q.size() != 2) begin
      $display("mtime reads got %0d responses instead of 2 (trace line %0d)", cap_q.size(),
               line_no);
      err_cnt++;
    end else begin
      e.valid = 1'b1;
      e.err   = 1'b0;  // mtime lies inside the CLINT region
      e.rdata = cap_q[0].rdata + delta;
      check_rsp(cap_q[1], e);
    end
  endtask

  task automatic run_pwm(input int skip, input int window, input logic [4:0] exp);
    logic [4:0] cnt;
    repeat (skip) @(negedge clk);
    cnt = '0;
    repeat (window) begin
      @(negedge clk);
      if (fan_pwm) cnt++;
    end
    check_bit("fan_pwm_o high cycles", cnt, exp);
  endtask

  task automatic end_test();
    if (in_test) begin
      drain();
      if (err_cnt == test_err0) begin
        pass_cnt++;
        $display("[PASS] %0s", test_name);
      end else begin
        fail_cnt++;
        $display("[FAIL] %0s with %0d errors", test_name, err_cnt - test_err0);
      end
    end
    in_test = 1'b0;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [8*128-1:0] line_s;
    logic [127:0]     op_s;
    logic [63:0]      a;
    logic [63:0]      d;
    logic [63:0]      e;
    int               fd;
    int               n;
    cpu_resetn = 1'b0;
    clk_locked = 1'b0;
    ndmreset   = 1'b0;
    bus_req    = '0;
    req_mode   = MODE_NONE;
    sw         = 8'ha5;
    repeat (4) @(posedge clk);
    cpu_resetn <= 1'b1;

    fd = $fopen("tb/soc_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/soc_trace.txt");
      err_cnt++;
    end else begin
      while ($fgets(line_s, fd) != 0) begin
        line_no++;
        op_s = '0;
        n = $sscanf(line_s, "%s %h %h %h", op_s, a, d, e);
        if (n < 1 || op_s == "#") continue;
        if (op_s == "test") begin
          end_test();
          test_name = '0;
          n = $sscanf(line_s, "%s %s", op_s, test_name);
          test_err0 = err_cnt;
          in_test   = 1'b1;
        end else if (op_s == "read" || op_s == "write") begin
          // Consecutive bus lines go out on consecutive cycles
          issue_checked(op_s == "write" ? BUS_WRITE : BUS_READ, a[31:0], d, 8'hff, e);
        end else begin
          drain();
          case (op_s)
            "lock":    run_lock(d[0], int'(e));
            "ndm":     run_ndm(int'(d));
            "ram":     run_ram(int'(d));
            "irqwait": run_irqwait(a[0], int'(d), e[0]);
            "mtime":   run_mtime(a[31:0], int'(d), e);
            "pwm":     run_pwm(int'(a), int'(d), e[4:0]);
            "led": begin
              @(negedge clk);
              check_led(led, e[7:0]);
            end
            default: begin
              $display("Unknown operation in trace line %0d", line_no);
              err_cnt++;
            end
          endcase
        end
      end
      end_test();
      $fclose(fd);
    end

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt,
             err_cnt);
    if (err_cnt == 0 && fail_cnt == 0 && pass_cnt > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* xbar/bus_xbar.sv */
`default_nettype none

`include "soc_defines.svh"

module bus_xbar (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  soc_bus_pkg::bus_req_t       bus_req_i,
  output soc_bus_pkg::bus_rsp_t       bus_rsp_o,
  output logic                        rom_sel_o,
  output logic                        clint_sel_o,
  output logic                        gpio_sel_o,
  output soc_bus_pkg::bus_req_t       slv_req_o,
  input  soc_map_pkg::slave_rsp_vec_t slv_rdata_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  // Region table, entry i belongs to region_e value i
  localparam logic [NUM_SLV-1:0][`SOC_ADDR_W-1:0] REGION_BASE = {
    `SOC_GPIO_BASE, `SOC_CLINT_BASE, `SOC_ROM_BASE
  };
  localparam logic [NUM_SLV-1:0][`SOC_ADDR_W-1:0] REGION_LEN = {
    `SOC_GPIO_LEN, `SOC_CLINT_LEN, `SOC_ROM_LEN
  };

  region_e                region;
  logic [`SOC_ADDR_W-1:0] offset;
  logic                   rsp_valid_q;
  logic                   rd_q;
  region_e                region_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  always_comb begin
    region = REG_NONE;
    offset = '0;
    for (int i = 0; i < NUM_SLV; i++) begin
      // Unsigned wrap makes addresses below the base fail too
      if ((bus_req_i.addr - REGION_BASE[i]) < REGION_LEN[i]) begin
        region = region_e'(2'(i));
        offset = bus_req_i.addr - REGION_BASE[i];
      end
    end
  end

  assign rom_sel_o   = bus_req_i.req && (region == REG_ROM);
  assign clint_sel_o = bus_req_i.req && (region == REG_CLINT);
  assign gpio_sel_o  = bus_req_i.req && (region == REG_GPIO);

  always_comb begin
    slv_req_o      = bus_req_i;
    slv_req_o.req  = bus_req_i.req && (region != REG_NONE);
    slv_req_o.addr = offset;
  end

  // --------------------------------------------------
  // Response path, fixed one cycle after req
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rd_q        <= 1'b0;
      region_q    <= REG_NONE;
    end else begin
      rsp_valid_q <= bus_req_i.req;
      rd_q        <= bus_req_i.req && (bus_req_i.op == BUS_READ);
      region_q    <= region;
    end
  end

  // Register slaves answer combinationally, capture here
  always_ff @(posedge clk) begin
    case (region)
      REG_CLINT: rdata_q <= slv_rdata_i[REG_CLINT];
      REG_GPIO:  rdata_q <= slv_rdata_i[REG_GPIO];
      default:   rdata_q <= '0;
    endcase
  end

  always_comb begin
    bus_rsp_o.valid = rsp_valid_q;
    bus_rsp_o.err   = rsp_valid_q && (region_q == REG_NONE);
    bus_rsp_o.rdata = '0;  // Writes and errors return zero
    if (rd_q) begin
      case (region_q)
        REG_ROM:   bus_rsp_o.rdata = slv_rdata_i[REG_ROM];  // Already registered in the RAM
        REG_CLINT,
        REG_GPIO:  bus_rsp_o.rdata = rdata_q;
        default:   bus_rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire
